/* tb/synth_vectors.txt */
# Columns: name freq_select wave_select attack sustain tick_period
# wave_select 0 triangle, 1 sawtooth, 2 square, 3 silent
# tick_period is the divider threshold plus one, in clock cycles
b2_silent        11 3   6   3 791
g3_triangle      19 0  10   5 499
c4_square_jump   24 2   8 200 374
a5_triangle      45 0 200 120 111
c6_sawtooth      48 1 247 255  94
b6_square        59 2 100  60  50
note62_sawtooth  62 1  40  20 222
a6_silent        57 3  50  25  56
d6_triangle_jump 50 0  20  90  84

/* all.f */
rtl/synth_pkg.sv
rtl/pitch_divider.sv
rtl/oscillator_bank.sv
rtl/envelope_generator.sv
rtl/voice_output_stage.sv
rtl/synth_voice.sv
tb/tb_synth_voice.sv

/* Bender.yml */
package:
  name: synth_voice

sources:
  - rtl/synth_pkg.sv
  - rtl/pitch_divider.sv
  - rtl/oscillator_bank.sv
  - rtl/envelope_generator.sv
  - rtl/voice_output_stage.sv
  - rtl/synth_voice.sv
  - target: test
    files:
      - tb/tb_synth_voice.sv

/* tb/tb_synth_voice.sv */
`timescale 1ns/100ps

module tb_synth_voice;

    logic                           clk;
    logic                           reset;
    logic [synth_pkg::note_w-1:0]   freq_select;
    synth_pkg::wave_sel_e           wave_select;
    logic [synth_pkg::sample_w-1:0] attack;
    logic [synth_pkg::sample_w-1:0] decay;
    logic [synth_pkg::sample_w-1:0] sustain;
    logic [synth_pkg::sample_w-1:0] wave_out;
    logic [synth_pkg::sample_w-1:0] amplitude;

    int seed;
    int err_cnt;
    int pass_cnt;
    int fail_cnt;
    int cycle_cnt;
    int chg_cycle[$];                              // Cycle of each amplitude change
    logic [synth_pkg::sample_w-1:0] chg_val[$];    // New amplitude at that change
    logic [synth_pkg::sample_w-1:0] wave_q[$];     // wave_out once per tick during the hold
    logic [synth_pkg::sample_w-1:0] last_amp;

    synth_voice i_dut (
        .clk         (clk),
        .reset       (reset),
        .freq_select (freq_select),
        .wave_select (wave_select),
        .attack      (attack),
        .decay       (decay),
        .sustain     (sustain),
        .wave_out    (wave_out),
        .amplitude   (amplitude)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Records every amplitude change away from the edges that move it
    always @(negedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (reset) begin
            last_amp = '0;
        end else if (amplitude !== last_amp) begin
            chg_cycle.push_back(cycle_cnt);
            chg_val.push_back(amplitude);
            last_amp = amplitude;
        end
    end

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s (%s): expected %0d, actual %0d",
                     test, what, expected, actual);
            err_cnt = err_cnt + 1;
        end
    endtask

    // Threshold from the octave 2 table, one right shift per octave, plus one
    function automatic int expected_period(input int note);
        int n;
        n = (note >= synth_pkg::num_notes) ? synth_pkg::default_note : note;
        return (synth_pkg::note_base_threshold[n % synth_pkg::notes_per_octave]
                >> (n / synth_pkg::notes_per_octave)) + 1;
    endfunction

    // Scaled waveform at tick phase t of a 512 tick cycle
    function automatic int model_sample(input int wave, input int t, input int sus);
        int p;
        int raw;
        p = t % 512;
        case (wave)
            0:       raw = (p < 256) ? p : 511 - p;
            1:       raw = p % 256;
            2:       raw = ((p % 256) < synth_pkg::square_half_ticks) ? 0 : 255;
            default: raw = 0;
        endcase
        return (raw * sus) >> 8;
    endfunction

    task automatic wait_level(input string test, input string what, input int level,
                              input int limit, inout bit ok);
        int cnt;
        cnt = 0;
        while (ok && amplitude != level && cnt < limit) begin
            @(negedge clk);
            cnt = cnt + 1;
        end
        if (ok && cnt >= limit) begin
            $display("Timeout in %s while waiting for %s", test, what);
            err_cnt = err_cnt + 1;
            ok = 1'b0;
        end
    endtask

    // Expected change values and their spacing in ticks
    // A spacing of 0 is not checked
    task automatic check_envelope(input string test, input int att, input int sus,
                                  input int period);
        int exp_val[$];
        int exp_gap[$];
        int rel_gap;
        int v;
        int i;
        int n;
        int errs;
        for (v = 1; v <= att; v++) begin
            exp_val.push_back(v);
            exp_gap.push_back((v == 1) ? 0 : 1);
        end
        if (sus < att) begin
            for (v = att - 1; v >= sus; v--) begin
                exp_val.push_back(v);
                exp_gap.push_back((v == att - 1) ? 2 : 1);   // Turn at the peak
            end
            rel_gap = synth_pkg::hold_ticks + 2;
        end else begin
            exp_val.push_back(sus);                          // Jump to the higher sustain
            exp_gap.push_back(3);
            rel_gap = synth_pkg::hold_ticks;
        end
        for (v = sus - 1; v >= 0; v--) begin
            exp_val.push_back(v);
            exp_gap.push_back((v == sus - 1) ? rel_gap : 1);
        end
        exp_val.push_back(1);                                // Next attack after idle
        exp_gap.push_back(synth_pkg::hold_ticks + 2);
        check_value(test, "amplitude change count", exp_val.size(), chg_val.size());
        n = (exp_val.size() < chg_val.size()) ? exp_val.size() : chg_val.size();
        errs = err_cnt;
        for (i = 0; i < n && err_cnt == errs; i++) begin
            check_value(test, "amplitude step", exp_val[i], chg_val[i]);
            if (exp_gap[i] != 0 && i > 0) begin
                check_value(test, "step spacing in cycles", exp_gap[i] * period,
                            chg_cycle[i] - chg_cycle[i-1]);
            end
        end
    endtask

    // Aligns the model on the best tick phase and compares every sample
    task automatic check_wave(input string test, input int wave, input int sus);
        int off;
        int k;
        int errs;
        int best_off;
        int best_err;
        if (wave_q.size() < 16) begin
            $display("Too few samples in the sustain hold of %s", test);
            err_cnt = err_cnt + 1;
        end else begin
            best_off = 0;
            best_err = wave_q.size() + 1;
            for (off = 0; off < 512; off++) begin
                errs = 0;
                for (k = 0; k < wave_q.size(); k++) begin
                    if (model_sample(wave, off + k, sus) != wave_q[k]) errs++;
                end
                if (errs < best_err) begin
                    best_err = errs;
                    best_off = off;
                end
            end
            errs = err_cnt;
            for (k = 0; k < wave_q.size() && err_cnt == errs; k++) begin
                check_value(test, "wave_out during hold",
                            model_sample(wave, best_off + k, sus), wave_q[k]);
            end
        end
    endtask

    task automatic run_test(input string name, input int note, input int wave,
                            input int att, input int sus, input int file_period);
        int period;
        int errs_before;
        int cnt;
        int limit;
        bit peak_seen;
        bit ok;
        errs_before = err_cnt;
        ok = 1'b1;
        period = expected_period(note);
        if (file_period >= 0) check_value(name, "tick period from table", period, file_period);

        @(posedge clk);
        freq_select <= note[synth_pkg::note_w-1:0];
        wave_select <= synth_pkg::wave_sel_e'(wave[1:0]);
        attack      <= att[synth_pkg::sample_w-1:0];
        sustain     <= sus[synth_pkg::sample_w-1:0];
        decay       <= $random(seed);              // Has no effect on the envelope
        reset       <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        chg_cycle.delete();
        chg_val.delete();
        wave_q.delete();
        @(negedge clk);
        check_value(name, "amplitude after reset", 0, amplitude);
        check_value(name, "wave_out after reset", 0, wave_out);

        // Past the peak and settled on the sustain level
        peak_seen = 1'b0;
        cnt = 0;
        limit = (synth_pkg::hold_ticks + 2 * 256 + 16) * period;
        while (!(peak_seen && amplitude == sus) && cnt < limit) begin
            @(negedge clk);
            cnt = cnt + 1;
            if (amplitude == att) peak_seen = 1'b1;
        end
        if (cnt >= limit) begin
            $display("Timeout in %s while waiting for the sustain level", name);
            err_cnt = err_cnt + 1;
            ok = 1'b0;
        end

        if (ok) begin
            repeat (period / 2) @(negedge clk);    // Sample mid tick where outputs are settled
            while (amplitude == sus && wave_q.size() <= synth_pkg::hold_ticks + 8) begin
                wave_q.push_back(wave_out);
                repeat (period) @(negedge clk);
            end
            if (wave_q.size() > synth_pkg::hold_ticks + 8) begin
                $display("Timeout in %s while waiting for the sustain hold to end", name);
                err_cnt = err_cnt + 1;
                ok = 1'b0;
            end
        end

        wait_level(name, "the release to reach 0", 0, (256 + 8) * period, ok);
        wait_level(name, "the next attack", 1, (synth_pkg::hold_ticks + 8) * period, ok);
        if (ok) begin
            @(negedge clk);
            check_envelope(name, att, sus, period);
            check_wave(name, wave, sus);
        end

        if (err_cnt == errs_before) begin
            pass_cnt = pass_cnt + 1;
            $display("%-18s passed", name);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("%-18s failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int fd;
        int rc;
        int note;
        int wave;
        int att;
        int sus;
        int per;
        string line;
        string name;

        seed        = 32'ha418_69a8;
        err_cnt     = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        cycle_cnt   = 0;
        last_amp    = '0;
        reset       = 1'b1;
        freq_select = '0;
        wave_select = synth_pkg::wave_silent;
        attack      = '0;
        decay       = '0;
        sustain     = '0;

        fd = $fopen("tb/synth_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file tb/synth_vectors.txt");
            $display("TEST FAILED");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc == 0 || line.len() == 0 || line.substr(0, 0) == "#") continue;
                rc = $sscanf(line, "%s %d %d %d %d %d", name, note, wave, att, sus, per);
                if (rc == 6) begin
                    run_test(name, note, wave, att, sus, per);
                end else if (rc > 0) begin
                    $display("Malformed vector line: %s", line);
                    fail_cnt = fail_cnt + 1;
                end
            end
            $fclose(fd);

            // Two extra settings with random levels
            att = 16 + ($unsigned($random(seed)) % 64);
            sus = 2 + ($unsigned($random(seed)) % (att - 2));
            run_test("random_decay", 59, 0, att, sus, -1);
            att = 8 + ($unsigned($random(seed)) % 64);
            sus = att + 1 + ($unsigned($random(seed)) % (255 - att));
            run_test("random_jump", 50, 2, att, sus, -1);

            $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

endmodule

/* rtl/synth_voice.sv */
`timescale 1ns/100ps

module synth_voice (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [synth_pkg::note_w-1:0]   freq_select,
    input  synth_pkg::wave_sel_e           wave_select,
    input  logic [synth_pkg::sample_w-1:0] attack,
    input  logic [synth_pkg::sample_w-1:0] decay,      // Unused, decay rate is fixed
    input  logic [synth_pkg::sample_w-1:0] sustain,
    output logic [synth_pkg::sample_w-1:0] wave_out,
    output logic [synth_pkg::sample_w-1:0] amplitude
);

    logic                           tick;
    logic [synth_pkg::sample_w-1:0] triangle;
    logic [synth_pkg::sample_w-1:0] sawtooth;
    logic [synth_pkg::sample_w-1:0] square;

    pitch_divider i_pitch_divider (
        .clk         (clk),
        .reset       (reset),
        .freq_select (freq_select),
        .tick        (tick)
    );

    oscillator_bank i_oscillator_bank (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .triangle (triangle),
        .sawtooth (sawtooth),
        .square   (square)
    );

    envelope_generator i_envelope_generator (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .attack    (attack),
        .sustain   (sustain),
        .amplitude (amplitude)
    );

    // Output lags the amplitude by one clock
    voice_output_stage i_voice_output_stage (
        .clk         (clk),
        .reset       (reset),
        .wave_select (wave_select),
        .triangle    (triangle),
        .sawtooth    (sawtooth),
        .square      (square),
        .amplitude   (amplitude),
        .wave_out    (wave_out)
    );

endmodule

/* rtl/voice_output_stage.sv */
`timescale 1ns/100ps

module voice_output_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  synth_pkg::wave_sel_e           wave_select,
    input  logic [synth_pkg::sample_w-1:0] triangle,
    input  logic [synth_pkg::sample_w-1:0] sawtooth,
    input  logic [synth_pkg::sample_w-1:0] square,
    input  logic [synth_pkg::sample_w-1:0] amplitude,
    output logic [synth_pkg::sample_w-1:0] wave_out
);

    logic [synth_pkg::sample_w-1:0]   selected;
    logic [2*synth_pkg::sample_w-1:0] scaled;

    always_comb begin
        case (wave_select)
            synth_pkg::wave_triangle: selected = triangle;
            synth_pkg::wave_sawtooth: selected = sawtooth;
            synth_pkg::wave_square:   selected = square;
            default:                  selected = '0;   // Silent
        endcase
    end

    assign scaled = selected * amplitude;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wave_out <= '0;
        end else begin
            wave_out <= scaled[2*synth_pkg::sample_w-1:synth_pkg::sample_w];  // Divide by 256
        end
    end

endmodule

/* rtl/envelope_generator.sv */
`timescale 1ns/100ps

module envelope_generator (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           tick,
    input  logic [synth_pkg::sample_w-1:0] attack,
    input  logic [synth_pkg::sample_w-1:0] sustain,
    output logic [synth_pkg::sample_w-1:0] amplitude
);

    synth_pkg::adsr_state_e               state;
    logic [synth_pkg::hold_cnt_w-1:0]     hold_cnt;   // Idle and sustain timer

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= synth_pkg::adsr_idle;
            amplitude <= '0;
            hold_cnt  <= '0;
        end else if (tick) begin
            case (state)
                synth_pkg::adsr_idle: begin
                    if (hold_cnt == synth_pkg::hold_last) begin
                        state    <= synth_pkg::adsr_attack;
                        hold_cnt <= '0;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                synth_pkg::adsr_attack: begin
                    if (amplitude < attack) begin
                        amplitude <= amplitude + 1'b1;
                    end else begin
                        state <= synth_pkg::adsr_decay;    // Peak reached
                    end
                end
                synth_pkg::adsr_decay: begin
                    if (amplitude > sustain) begin
                        amplitude <= amplitude - 1'b1;     // Fixed rate, one per tick
                    end else begin
                        state <= synth_pkg::adsr_sustain;
                    end
                end
                synth_pkg::adsr_sustain: begin
                    // Jumps up here when sustain exceeds attack
                    amplitude <= sustain;
                    if (hold_cnt == synth_pkg::hold_last) begin
                        state    <= synth_pkg::adsr_release;
                        hold_cnt <= '0;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                synth_pkg::adsr_release: begin
                    if (amplitude > '0) begin
                        amplitude <= amplitude - 1'b1;
                    end else begin
                        state <= synth_pkg::adsr_idle;
                    end
                end
                default: begin
                    state <= synth_pkg::adsr_idle;         // Recover from unused codes
                end
            endcase
        end
    end

endmodule

/* rtl/oscillator_bank.sv */
`timescale 1ns/100ps

module oscillator_bank (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           tick,
    output logic [synth_pkg::sample_w-1:0] triangle,
    output logic [synth_pkg::sample_w-1:0] sawtooth,
    output logic [synth_pkg::sample_w-1:0] square
);

    logic                                 tri_up;      // Triangle direction
    logic [synth_pkg::square_cnt_w-1:0]   square_cnt;

    // Sawtooth phase wraps modulo 256
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sawtooth <= '0;
        end else if (tick) begin
            sawtooth <= sawtooth + 1'b1;
        end
    end

    // Triangle spends one tick at each turning point
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            triangle <= '0;
            tri_up   <= 1'b1;
        end else if (tick) begin
            if (tri_up) begin
                if (triangle < synth_pkg::sample_max) begin
                    triangle <= triangle + 1'b1;
                end else begin
                    tri_up <= 1'b0;                    // Turn at the peak
                end
            end else begin
                if (triangle > '0) begin
                    triangle <= triangle - 1'b1;
                end else begin
                    tri_up <= 1'b1;                    // Turn at zero
                end
            end
        end
    end

    // Square toggles between 0 and full scale every half period
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            square_cnt <= '0;
            square     <= '0;                          // Starts low
        end else if (tick) begin
            if (square_cnt == synth_pkg::square_last) begin
                square_cnt <= '0;
                square     <= ~square;
            end else begin
                square_cnt <= square_cnt + 1'b1;
            end
        end
    end

endmodule

/* rtl/pitch_divider.sv */
`timescale 1ns/100ps

module pitch_divider (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [synth_pkg::note_w-1:0] freq_select,
    output logic                         tick
);

    logic [synth_pkg::note_w-1:0]     note_idx;
    logic [synth_pkg::octave_w-1:0]   octave;
    logic [synth_pkg::semitone_w-1:0] semitone;
    logic [synth_pkg::div_w-1:0]      threshold;
    logic [synth_pkg::div_w-1:0]      div_cnt;

    // Out of range notes play A4
    always_comb begin
        if (freq_select >= synth_pkg::num_notes) begin
            note_idx = synth_pkg::note_w'(synth_pkg::default_note);
        end else begin
            note_idx = freq_select;
        end
    end

    assign octave   = synth_pkg::octave_w'(note_idx / synth_pkg::notes_per_octave);
    assign semitone = synth_pkg::semitone_w'(note_idx % synth_pkg::notes_per_octave);

    // One octave up halves the threshold
    assign threshold = synth_pkg::note_base_threshold[semitone] >> octave;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            if (div_cnt >= threshold) begin  // Also catches a threshold lowered mid-count
                div_cnt <= '0;
                tick    <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                tick    <= 1'b0;
            end
        end
    end

endmodule

/* rtl/synth_pkg.sv */
package synth_pkg;

    // Data widths
    localparam int sample_w = 8;                  // Samples, amplitudes, envelope levels
    localparam int note_w   = 6;                  // Note number input
    localparam int div_w    = 12;                 // Divider count and threshold

    localparam logic [sample_w-1:0] sample_max = {sample_w{1'b1}};

    // Note and octave layout
    localparam int notes_per_octave = 12;
    localparam int num_octaves      = 5;          // Octaves 2 to 6
    localparam int num_notes        = notes_per_octave * num_octaves;
    localparam int default_note     = 33;         // A4
    localparam int octave_w         = $clog2(num_octaves);
    localparam int semitone_w       = $clog2(notes_per_octave);

    // Octave 2 divider thresholds, C to B
    // Each is 25 MHz / (256 * f) - 1, higher octaves shift right
    localparam logic [div_w-1:0] note_base_threshold [0:notes_per_octave-1] = '{
        12'd1492,                                 // C2
        12'd1408,                                 // C#2
        12'd1329,                                 // D2
        12'd1255,                                 // D#2
        12'd1184,                                 // E2
        12'd1118,                                 // F2
        12'd1055,                                 // F#2
        12'd996,                                  // G2
        12'd940,                                  // G#2
        12'd887,                                  // A2
        12'd837,                                  // A#2
        12'd790                                   // B2
    };

    // Envelope hold phases
    localparam int hold_ticks = 256;              // Idle and sustain length
    localparam int hold_cnt_w = $clog2(hold_ticks);
    localparam logic [hold_cnt_w-1:0] hold_last = hold_cnt_w'(hold_ticks - 1);

    // Square wave half period
    localparam int square_half_ticks = 128;
    localparam int square_cnt_w      = $clog2(square_half_ticks);
    localparam logic [square_cnt_w-1:0] square_last = square_cnt_w'(square_half_ticks - 1);

    typedef enum logic [1:0] {
        wave_triangle,
        wave_sawtooth,
        wave_square,
        wave_silent                               // Replaces the old sine slot
    } wave_sel_e;

    typedef enum logic [2:0] {
        adsr_idle,
        adsr_attack,
        adsr_decay,
        adsr_sustain,
        adsr_release
    } adsr_state_e;

endpackage
